//--- Makefile
VERILATOR ?= verilator
TOP ?= itim_tb
RTL_TOP ?= itim_top
FILELIST ?= itim_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_TEXT ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- itim_top.f
rtl/itim_pkg.sv
rtl/itim_ram_if.sv
rtl/itim_ram.sv
rtl/itim_lookup.sv
rtl/itim_flush.sv
rtl/itim_ctrl.sv
rtl/itim_top.sv
verification/itim_mem_model.sv
verification/itim_tb.sv

//--- rtl/itim_ctrl.sv
`default_nettype none

module itim_ctrl import itim_pkg::*; (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic [addr_width-1:0] req_addr,
  output logic rsp_ready,
  output logic [data_width-1:0] rsp_data,
  output logic mem_valid,
  output logic [addr_width-1:0] mem_addr,
  input logic mem_ready,
  input logic [data_width-1:0] mem_rdata,
  output logic [addr_width-1:0] line_addr,
  input outcome_type outcome,
  input logic [data_width-1:0] hit_data,
  output logic flush_start,
  input logic [set_bits-1:0] flush_index,
  input logic flush_last,
  itim_ram_if.owner banks [bank_count]
);

  state_type state;
  logic req_pending;
  logic req_is_fence;
  logic [bank_count-1:0] bank_wen;
  logic [set_bits-1:0] bank_waddr;
  line_type bank_wdata;

  // ==============================
  // Request register
  // ==============================
  always_ff @(posedge clock) begin
    if (!reset) begin
      req_pending <= 1'b0;
    end else begin
      req_pending <= req_valid && (state == st_lookup);
    end
  end

  always_ff @(posedge clock) begin
    if (req_valid) begin
      line_addr <= req_addr;
      req_is_fence <= req_fence;
    end
  end

  assign flush_start = (state == st_lookup) && req_pending && req_is_fence;

  // ==============================
  // State machine and response
  // ==============================
  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= st_lookup;
      rsp_ready <= 1'b0;
      mem_valid <= 1'b0;
    end else begin
      rsp_ready <= 1'b0;
      case (state)
        st_lookup: begin
          if (flush_start) begin
            state <= st_flush;
          end else if (req_pending) begin
            case (outcome)
              outcome_hit: rsp_ready <= 1'b1;
              outcome_fill: begin
                state <= st_fill;
                mem_valid <= 1'b1;
              end
              default: begin
                state <= st_bypass;
                mem_valid <= 1'b1;
              end
            endcase
          end
        end
        st_fill, st_bypass: begin
          if (mem_ready) begin
            state <= st_lookup;
            mem_valid <= 1'b0;
            rsp_ready <= 1'b1;
          end
        end
        default: begin
          if (flush_last) begin
            state <= st_lookup;
            rsp_ready <= 1'b1;
          end
        end
      endcase
    end
  end

  // Response data and memory address
  always_ff @(posedge clock) begin
    if (state == st_lookup) begin
      mem_addr <= line_addr;
      rsp_data <= hit_data;
    end else if (state == st_flush) begin
      rsp_data <= '0;
    end else if (mem_ready) begin
      rsp_data <= mem_rdata;
    end
  end

  // ==============================
  // Bank ports
  // ==============================
  always_comb begin
    bank_wen = '0;
    bank_waddr = line_addr[set_lsb +: set_bits];
    bank_wdata = '{lock: 1'b1, tag: line_addr[tag_lsb +: tag_bits], data: mem_rdata};
    if (state == st_flush) begin
      bank_wen = '1;
      bank_waddr = flush_index;
      bank_wdata = '0;
    end else if ((state == st_fill) && mem_ready) begin
      bank_wen[line_addr[bank_lsb +: bank_bits]] = 1'b1;
    end
  end

  for (genvar g = 0; g < bank_count; g++) begin : g_bank
    assign banks[g].wen = bank_wen[g];
    assign banks[g].waddr = bank_waddr;
    assign banks[g].wdata = bank_wdata;
    // Read index straight from the fetch port
    assign banks[g].raddr = req_addr[set_lsb +: set_bits];
  end

endmodule

`default_nettype wire

//--- rtl/itim_flush.sv
`default_nettype none

module itim_flush import itim_pkg::*; (
  input logic clock,
  input logic reset,
  input logic start,
  output logic [set_bits-1:0] index,
  output logic last
);

  logic running;

  always_ff @(posedge clock) begin
    if (!reset) begin
      running <= 1'b0;
      index <= '0;
    end else if (start) begin
      running <= 1'b1;
      index <= '0;
    end else if (running) begin
      if (last) begin
        running <= 1'b0;
      end else begin
        index <= index + 1'b1;
      end
    end
  end

  // Counter holds on the final index
  assign last = running && (index == set_bits'(set_count - 1));

endmodule

`default_nettype wire

//--- rtl/itim_lookup.sv
`default_nettype none

module itim_lookup import itim_pkg::*; (
  itim_ram_if.reader banks [bank_count],
  input logic [addr_width-1:0] line_addr,
  input logic fence,
  output outcome_type outcome,
  output logic [data_width-1:0] hit_data
);

  line_type bank_lines [bank_count];
  line_type line;
  logic [bank_bits-1:0] bank_sel;
  logic [tag_bits-1:0] req_tag;
  logic in_window;

  // Gather each bank's read line
  for (genvar g = 0; g < bank_count; g++) begin : g_bank
    assign bank_lines[g] = banks[g].rdata;
  end

  assign bank_sel = line_addr[bank_lsb +: bank_bits];
  assign req_tag = line_addr[tag_lsb +: tag_bits];
  assign line = bank_lines[bank_sel];

  assign in_window = (line_addr >= itim_base_addr) && (line_addr < itim_top_addr);

  // ==============================
  // Classification
  // ==============================
  always_comb begin
    if (!in_window) begin
      outcome = outcome_bypass;
    end else if (!line.lock) begin
      outcome = outcome_fill;
    end else if (line.tag != req_tag) begin
      outcome = outcome_bypass;
    end else begin
      outcome = outcome_hit;
    end
  end

  assign hit_data = line.data;

endmodule

`default_nettype wire

//--- rtl/itim_pkg.sv
`default_nettype none

package itim_pkg;

  // ==============================
  // Geometry
  // ==============================
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int bank_count = 2;
  localparam int set_count = 64;
  localparam int bank_bits = $clog2(bank_count);
  localparam int set_bits = $clog2(set_count);
  localparam int tag_bits = addr_width - 2 - bank_bits - set_bits;

  // Address fields above the word offset
  localparam int bank_lsb = 2;
  localparam int set_lsb = bank_lsb + bank_bits;
  localparam int tag_lsb = set_lsb + set_bits;

  // Window is wider than storage
  localparam logic [addr_width-1:0] itim_base_addr = 32'h0000_1000;
  localparam logic [addr_width-1:0] itim_top_addr = 32'h0000_2000;

  // ==============================
  // Types
  // ==============================
  typedef struct packed {
    logic lock;
    logic [tag_bits-1:0] tag;
    logic [data_width-1:0] data;
  } line_type;

  typedef enum logic [1:0] {
    outcome_hit,
    outcome_fill,
    outcome_bypass
  } outcome_type;

  typedef enum logic [1:0] {
    st_lookup,
    st_fill,
    st_bypass,
    st_flush
  } state_type;

endpackage

`default_nettype wire

//--- rtl/itim_ram.sv
`default_nettype none

module itim_ram import itim_pkg::*; (
  input logic clock,
  itim_ram_if.store bank
);

  line_type lines [set_count];
  logic [set_bits-1:0] raddr_q;

  // Write port
  always_ff @(posedge clock) begin
    if (bank.wen) begin
      lines[bank.waddr] <= bank.wdata;
    end
  end

  // Registered index gives a one cycle read
  always_ff @(posedge clock) begin
    raddr_q <= bank.raddr;
  end

  assign bank.rdata = lines[raddr_q];

endmodule

`default_nettype wire

//--- rtl/itim_ram_if.sv
`default_nettype none

interface itim_ram_if import itim_pkg::*; ();

  logic wen;
  logic [set_bits-1:0] waddr;
  line_type wdata;
  logic [set_bits-1:0] raddr;
  line_type rdata;

  modport owner (
    output wen,
    output waddr,
    output wdata,
    output raddr
  );

  modport store (
    input wen,
    input waddr,
    input wdata,
    input raddr,
    output rdata
  );

  modport reader (
    input rdata
  );

endinterface

`default_nettype wire

//--- rtl/itim_top.sv
`default_nettype none

module itim_top import itim_pkg::*; (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic req_fence,
  input logic [addr_width-1:0] req_addr,
  output logic rsp_ready,
  output logic [data_width-1:0] rsp_data,
  output logic mem_valid,
  output logic [addr_width-1:0] mem_addr,
  input logic mem_ready,
  input logic [data_width-1:0] mem_rdata
);

  logic [addr_width-1:0] line_addr;
  outcome_type outcome;
  logic [data_width-1:0] hit_data;
  logic flush_start;
  logic [set_bits-1:0] flush_index;
  logic flush_last;

  itim_ram_if bank_if [bank_count] ();

  for (genvar g = 0; g < bank_count; g++) begin : g_ram
    itim_ram ram_inst (
      .clock (clock),
      .bank (bank_if[g])
    );
  end

  itim_lookup lookup_inst (
    .banks (bank_if),
    .line_addr (line_addr),
    .fence (flush_start),
    .outcome (outcome),
    .hit_data (hit_data)
  );

  itim_flush flush_inst (
    .clock (clock),
    .reset (reset),
    .start (flush_start),
    .index (flush_index),
    .last (flush_last)
  );

  itim_ctrl ctrl_inst (
    .clock (clock),
    .reset (reset),
    .req_valid (req_valid),
    .req_fence (req_fence),
    .req_addr (req_addr),
    .rsp_ready (rsp_ready),
    .rsp_data (rsp_data),
    .mem_valid (mem_valid),
    .mem_addr (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .line_addr (line_addr),
    .outcome (outcome),
    .hit_data (hit_data),
    .flush_start (flush_start),
    .flush_index (flush_index),
    .flush_last (flush_last),
    .banks (bank_if)
  );

endmodule

`default_nettype wire

//--- verification/itim_mem_model.sv
`default_nettype none

module itim_mem_model import itim_pkg::*; #(
  parameter logic [data_width-1:0] hash_key = '0
) (
  input logic clock,
  input logic mem_valid,
  input logic [addr_width-1:0] mem_addr,
  output logic mem_ready,
  output logic [data_width-1:0] mem_rdata,
  output int request_count
);

  localparam int drive_delay = 2;

  integer seed = 90;
  logic busy = 1'b0;
  logic [1:0] wait_left = 2'd0;

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    request_count = 0;
  end

  always @(posedge clock) begin
    #drive_delay;
    // Ready high in the cycle just ended means the request was taken
    if (mem_ready) begin
      mem_ready = 1'b0;
      busy = 1'b0;
      request_count = request_count + 1;
    end
    if (mem_valid && !busy) begin
      busy = 1'b1;
      wait_left = 2'($random(seed));
    end
    if (busy && !mem_ready) begin
      if (wait_left == 2'd0) begin
        mem_ready = 1'b1;
        mem_rdata = {2'b00, mem_addr[addr_width-1:2]} ^ hash_key;
      end else begin
        wait_left = wait_left - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/itim_tb.sv
`default_nettype none

module itim_tb import itim_pkg::*; ();

  localparam int half_period = 20;
  localparam int drive_delay = 2;
  localparam int line_total = bank_count * set_count;
  localparam int conflict_count = 8;
  localparam int outside_repeat = 3;
  localparam int refill_count = 16;
  localparam int random_count = 200;
  localparam int request_total = 2 + 2 * line_total + 2 * conflict_count
    + 4 * outside_repeat + 2 * refill_count + random_count;
  localparam int cycle_limit = request_total * (set_count + 10);
  localparam logic [data_width-1:0] hash_key = 32'h5a3c_96e1;

  logic clock = 1'b0;
  logic reset;
  logic req_valid;
  logic req_fence;
  logic [addr_width-1:0] req_addr;
  logic rsp_ready;
  logic [data_width-1:0] rsp_data;
  logic mem_valid;
  logic [addr_width-1:0] mem_addr;
  logic mem_ready;
  logic [data_width-1:0] mem_rdata;
  int request_count;

  int cycle_count = 0;
  int data_errors = 0;
  int addr_errors = 0;
  int outcome_errors = 0;
  int latency_errors = 0;
  int protocol_errors = 0;
  integer seed = 90;
  logic rsp_expected = 1'b0;
  logic [data_width-1:0] expect_data = '0;
  logic [addr_width-1:0] expect_addr = '0;
  logic rsp_ready_prev = 1'b0;
  logic mem_valid_prev = 1'b0;
  logic mem_ready_prev = 1'b0;
  logic [addr_width-1:0] mem_addr_prev = '0;
  logic [addr_width-1:0] outside_addr [4];

  // Reference line state
  logic model_lock [bank_count][set_count];
  logic [tag_bits-1:0] model_tag [bank_count][set_count];

  always #half_period clock = ~clock;

  itim_top uut (
    .clock (clock),
    .reset (reset),
    .req_valid (req_valid),
    .req_fence (req_fence),
    .req_addr (req_addr),
    .rsp_ready (rsp_ready),
    .rsp_data (rsp_data),
    .mem_valid (mem_valid),
    .mem_addr (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

  itim_mem_model #(.hash_key (hash_key)) mem_model (
    .clock (clock),
    .mem_valid (mem_valid),
    .mem_addr (mem_addr),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .request_count (request_count)
  );

  // ==============================
  // Reference model
  // ==============================
  function automatic logic [data_width-1:0] expected_word(input logic [addr_width-1:0] addr);
    return {2'b00, addr[addr_width-1:2]} ^ hash_key;
  endfunction

  function automatic outcome_type predict_outcome(input logic [addr_width-1:0] addr);
    logic [bank_bits-1:0] bank;
    logic [set_bits-1:0] set_index;
    logic [tag_bits-1:0] tag;
    bank = addr[bank_lsb +: bank_bits];
    set_index = addr[set_lsb +: set_bits];
    tag = addr[tag_lsb +: tag_bits];
    if ((addr < itim_base_addr) || (addr >= itim_top_addr)) begin
      return outcome_bypass;
    end
    if (!model_lock[bank][set_index]) begin
      return outcome_fill;
    end
    if (model_tag[bank][set_index] != tag) begin
      return outcome_bypass;
    end
    return outcome_hit;
  endfunction

  task automatic clear_model();
    for (int b = 0; b < bank_count; b++) begin
      for (int s = 0; s < set_count; s++) begin
        model_lock[b][s] = 1'b0;
        model_tag[b][s] = '0;
      end
    end
  endtask

  task automatic record_fill(input logic [addr_width-1:0] addr);
    model_lock[addr[bank_lsb +: bank_bits]][addr[set_lsb +: set_bits]] = 1'b1;
    model_tag[addr[bank_lsb +: bank_bits]][addr[set_lsb +: set_bits]] =
      addr[tag_lsb +: tag_bits];
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic verify_data(input logic [data_width-1:0] got,
                             input logic [data_width-1:0] expected);
    if (got !== expected) begin
      data_errors++;
      $display("Fail rsp_data got 0x%08h expected 0x%08h", got, expected);
    end
  endtask

  task automatic verify_addr(input logic [addr_width-1:0] got,
                             input logic [addr_width-1:0] expected);
    if (got !== expected) begin
      addr_errors++;
      $display("Fail mem_addr got 0x%08h expected 0x%08h", got, expected);
    end
  endtask

  // Outcome seen through the number of memory requests it made
  task automatic judge_outcome(input outcome_type expected, input int requests,
                               input logic [addr_width-1:0] addr);
    int wanted;
    wanted = (expected == outcome_hit) ? 0 : 1;
    if (requests != wanted) begin
      outcome_errors++;
      $display("Fail mem request count got 0x%0h expected 0x%0h for %s at 0x%08h",
               requests, wanted, expected.name(), addr);
    end
  endtask

  task automatic check_latency(input int got, input int expected);
    if (got != expected) begin
      latency_errors++;
      $display("Fail rsp_ready latency got 0x%0h expected 0x%0h", got, expected);
    end
  endtask

  task automatic report_counts();
    $display("Errors: data %0d, address %0d, outcome %0d, latency %0d, protocol %0d",
             data_errors, addr_errors, outcome_errors, latency_errors, protocol_errors);
  endtask

  // One request from drive to response, then the model update
  task automatic run_request(input logic fence, input logic [addr_width-1:0] addr);
    outcome_type expected;
    int requests_before;
    int latency;
    begin
      expected = fence ? outcome_hit : predict_outcome(addr);
      expect_data = fence ? '0 : expected_word(addr);
      expect_addr = addr;
      requests_before = request_count;
      rsp_expected = 1'b1;
      req_valid = 1'b1;
      req_fence = fence;
      req_addr = addr;
      @(posedge clock);
      #drive_delay;
      req_valid = 1'b0;
      req_fence = 1'b0;
      // Counted from the lookup cycle
      latency = -1;
      do begin
        @(negedge clock);
        latency++;
      end while (rsp_ready !== 1'b1);
      @(posedge clock);
      #drive_delay;
      rsp_expected = 1'b0;
      judge_outcome(expected, request_count - requests_before, addr);
      if (fence) begin
        check_latency(latency, set_count + 1);
        clear_model();
      end else if (expected == outcome_hit) begin
        check_latency(latency, 1);
      end else if (expected == outcome_fill) begin
        record_fill(addr);
      end
    end
  endtask

  // ==============================
  // Checkers and timeout
  // ==============================
  always @(negedge clock) begin
    if (rsp_ready === 1'b1) begin
      if (!rsp_expected) begin
        protocol_errors++;
        $display("rsp_ready rose with no request outstanding");
      end else begin
        verify_data(rsp_data, expect_data);
      end
      if (rsp_ready_prev === 1'b1) begin
        protocol_errors++;
        $display("rsp_ready stayed high for more than one cycle");
      end
    end
    rsp_ready_prev = rsp_ready;
  end

  // Memory request must hold until it is accepted
  always @(negedge clock) begin
    if (mem_valid === 1'b1) begin
      verify_addr(mem_addr, expect_addr);
    end
    if ((mem_valid_prev === 1'b1) && (mem_ready_prev !== 1'b1)) begin
      if (mem_valid !== 1'b1) begin
        protocol_errors++;
        $display("mem_valid dropped before mem_ready was seen");
      end else if (mem_addr !== mem_addr_prev) begin
        protocol_errors++;
        $display("Fail mem_addr got 0x%08h expected 0x%08h", mem_addr, mem_addr_prev);
      end
    end
    mem_valid_prev = mem_valid;
    mem_ready_prev = mem_ready;
    mem_addr_prev = mem_addr;
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout after %0d cycles waiting for a response", cycle_count);
      report_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    logic [31:0] r;
    logic [addr_width-1:0] addr;
    reset = 1'b0;
    req_valid = 1'b0;
    req_fence = 1'b0;
    req_addr = '0;
    outside_addr[0] = itim_base_addr - 32'h4;
    outside_addr[1] = itim_base_addr - 32'h200;
    outside_addr[2] = itim_top_addr;
    outside_addr[3] = itim_top_addr + 32'h4;
    clear_model();
    repeat (4) @(posedge clock);
    #drive_delay;
    reset = 1'b1;
    @(posedge clock);
    #drive_delay;

    // Initial fence, then fill every line
    run_request(1'b1, '0);
    for (int i = 0; i < line_total; i++) begin
      run_request(1'b0, itim_base_addr + addr_width'(i * 4));
    end
    for (int i = 0; i < line_total; i++) begin
      run_request(1'b0, itim_base_addr + addr_width'(i * 4));
    end

    // Same lines under another tag
    for (int i = 0; i < conflict_count; i++) begin
      run_request(1'b0, itim_base_addr + addr_width'(line_total * 4 + i * 4));
      run_request(1'b0, itim_base_addr + addr_width'(i * 4));
    end

    for (int k = 0; k < outside_repeat; k++) begin
      for (int j = 0; j < 4; j++) begin
        run_request(1'b0, outside_addr[j]);
      end
    end

    // Fence clears locked lines
    run_request(1'b1, '0);
    for (int i = 0; i < refill_count; i++) begin
      run_request(1'b0, itim_base_addr + addr_width'(i * 4));
    end
    for (int i = 0; i < refill_count; i++) begin
      run_request(1'b0, itim_base_addr + addr_width'(i * 4));
    end

    for (int n = 0; n < random_count; n++) begin
      r = $random(seed);
      case (r[12:11])
        2'd0: addr = itim_base_addr - 32'h100 + addr_width'({r[5:0], 2'b00});
        2'd1: addr = itim_top_addr + addr_width'({r[5:0], 2'b00});
        default: addr = itim_base_addr + addr_width'({r[8:0], 2'b00});
      endcase
      run_request(r[17:13] == 5'd0, addr);
    end

    report_counts();
    if ((data_errors + addr_errors + outcome_errors + latency_errors
         + protocol_errors) == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
